//--- tickTimerCfgPkg.sv
`default_nettype none
//----------------------------------------------------------------------
// tickTimerCfgPkg
// timing-side definitions of the tick timer: counter width and the
// values that the divider, PWM and interval registers take at reset
//----------------------------------------------------------------------
package tickTimerCfgPkg;

	//------------------------------------------------------------------
	// counter geometry
	//------------------------------------------------------------------

	// every counter and compare value is one plain word
	localparam int cntWidth = 16;

	//------------------------------------------------------------------
	// reset values
	//------------------------------------------------------------------

	// divide by one, so a tick on every cycle once enabled
	localparam logic [cntWidth-1:0] prescaleReset = '0;

	// one tick per PWM period
	localparam logic [cntWidth-1:0] pwmPeriodReset = '0;

	// output stays low until a duty is written
	localparam logic [cntWidth-1:0] pwmDutyReset = '0;

	// expiry on every tick once enabled
	localparam logic [cntWidth-1:0] timerLoadReset = '0;

endpackage

`default_nettype wire

//--- tickTimerRegPkg.sv
`default_nettype none
//----------------------------------------------------------------------
// tickTimerRegPkg
// register map of the tick timer: word and address widths, register
// addresses and the bit positions inside control and status
//----------------------------------------------------------------------
package tickTimerRegPkg;

	// register port widths
	localparam int regAddrWidth = 4;
	localparam int regDataWidth = 16;

	//------------------------------------------------------------------
	// register addresses
	//------------------------------------------------------------------
	localparam logic [regAddrWidth-1:0] addrCtrl      = 4'd0;
	localparam logic [regAddrWidth-1:0] addrPrescale  = 4'd1;
	localparam logic [regAddrWidth-1:0] addrPwmPeriod = 4'd2;
	localparam logic [regAddrWidth-1:0] addrPwmDuty   = 4'd3;
	localparam logic [regAddrWidth-1:0] addrTimerLoad = 4'd4;
	// sticky interrupt, write 1 to clear
	localparam logic [regAddrWidth-1:0] addrStatus    = 4'd5;

	//------------------------------------------------------------------
	// control register bits
	//------------------------------------------------------------------
	// prescaler run
	localparam int ctrlTickEnBit      = 0;
	// PWM output run
	localparam int ctrlPwmEnBit       = 1;
	// interval timer run, cleared by hardware in one-shot mode
	localparam int ctrlTimerEnBit     = 2;
	// 1 keeps the timer running after expiry
	localparam int ctrlAutoReloadBit  = 3;

	//------------------------------------------------------------------
	// status register bits
	//------------------------------------------------------------------
	localparam int statusIrqBit = 0;

endpackage

`default_nettype wire

//--- ckeDivider.sv
`default_nettype none
//----------------------------------------------------------------------
// ckeDivider
// programmable clock enable generator; emits a one-cycle tick every
// divider+1 system clocks while tickEn is high
//----------------------------------------------------------------------
module ckeDivider
	import tickTimerCfgPkg::*;
(
	input  wire logic                iSysClk,
	input  wire logic                rstN,
	// run enable from the control register
	input  wire logic                tickEn,
	// terminal count, 0 gives a tick every cycle
	input  wire logic [cntWidth-1:0] divider,
	output logic                     tick
);

	// cycle counter inside one tick period
	logic [cntWidth-1:0] divCnt;
	// terminal count reached
	logic                divHit;

	// >= so that a divider lowered mid-count wraps at once
	// instead of running all the way round the word
	assign divHit = (divCnt >= divider);

	//------------------------------------------------------------------
	// counter and registered tick
	//------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			divCnt <= '0;
			tick   <= 1'b0;
		end
		else if (!tickEn)
		begin
			// parked at 0 so the first tick is divider+1 cycles out
			divCnt <= '0;
			tick   <= 1'b0;
		end
		else if (divHit)
		begin
			// restart the period and fire
			divCnt <= '0;
			tick   <= 1'b1;
		end
		else
		begin
			divCnt <= divCnt + 1'b1;
			tick   <= 1'b0;
		end
	end

	//------------------------------------------------------------------
	// checks
	//------------------------------------------------------------------

	// with a steady nonzero divider two ticks never come back to back
	assert property (@(posedge iSysClk) disable iff (!rstN)
		(tick && (divider != '0) && $stable(divider)) |=> !tick)
		else $error("ckeDivider: ticks closer than divider+1 cycles");

endmodule

`default_nettype wire

//--- pwmGen.sv
`default_nettype none
//----------------------------------------------------------------------
// pwmGen
// tick-driven PWM; period of pwmPeriod+1 ticks, high while the count
// is below pwmDuty, registered output
//----------------------------------------------------------------------
module pwmGen
	import tickTimerCfgPkg::*;
(
	input  wire logic                iSysClk,
	input  wire logic                rstN,
	input  wire logic                tick,
	input  wire logic                pwmEn,
	input  wire logic [cntWidth-1:0] pwmPeriod,
	input  wire logic [cntWidth-1:0] pwmDuty,
	output logic                     pwmOut
);

	// position inside the PWM period, in ticks
	logic [cntWidth-1:0] pwmCnt;
	// last count of the period
	logic                pwmWrap;

	// >= keeps the counter bounded when the period shrinks
	assign pwmWrap = (pwmCnt >= pwmPeriod);

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			pwmCnt <= '0;
			pwmOut <= 1'b0;
		end
		else if (!pwmEn)
		begin
			// forced low, restart from the top of a period
			pwmCnt <= '0;
			pwmOut <= 1'b0;
		end
		else if (tick)
		begin
			// compare before advancing, duty above period stays high
			pwmOut <= (pwmCnt < pwmDuty);
			if (pwmWrap)
				pwmCnt <= '0;
			else
				pwmCnt <= pwmCnt + 1'b1;
		end
	end

	// duty of 0 seen at a tick keeps the output low until duty changes
	assert property (@(posedge iSysClk) disable iff (!rstN)
		(tick && (pwmDuty == '0)) |=> (!pwmOut until (pwmDuty != '0)))
		else $error("pwmGen: pwmOut high with zero duty");

endmodule

`default_nettype wire

//--- intervalTimer.sv
`default_nettype none
//----------------------------------------------------------------------
// intervalTimer
// tick-driven down-counter with reload; one-cycle expire pulse every
// timerLoad+1 ticks while enabled
//----------------------------------------------------------------------
module intervalTimer
	import tickTimerCfgPkg::*;
(
	input  wire logic                iSysClk,
	input  wire logic                rstN,
	input  wire logic                tick,
	input  wire logic                timerEn,
	input  wire logic [cntWidth-1:0] timerLoad,
	// same cycle as the tick that finds the count at 0
	output logic                     expire
);

	// ticks left before expiry
	logic [cntWidth-1:0] timerCnt;
	logic                timerZero;

	assign timerZero = (timerCnt == '0);

	// combinational so expiry lines up with its tick
	assign expire = timerEn && tick && timerZero;

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			timerCnt <= timerLoadReset;
		else if (!timerEn)
			// follow the load register while stopped
			timerCnt <= timerLoad;
		else if (tick)
		begin
			// reload on expiry, otherwise count down
			if (timerZero)
				timerCnt <= timerLoad;
			else
				timerCnt <= timerCnt - 1'b1;
		end
	end

	//------------------------------------------------------------------
	// checks
	//------------------------------------------------------------------

	// every expiry starts a fresh interval from the load value
	assert property (@(posedge iSysClk) disable iff (!rstN)
		expire |=> (timerCnt == $past(timerLoad)))
		else $error("intervalTimer: no reload after expire");

endmodule

`default_nettype wire

//--- tickTimerCtrl.sv
`default_nettype none
//----------------------------------------------------------------------
// tickTimerCtrl
// register bank of the tick timer; write decode, read-back mux,
// sticky interrupt and the one-shot timer disable
//----------------------------------------------------------------------
module tickTimerCtrl
	import tickTimerRegPkg::*, tickTimerCfgPkg::*;
(
	input  wire logic                    iSysClk,
	input  wire logic                    rstN,
	// register port
	input  wire logic                    regWr,
	input  wire logic [regAddrWidth-1:0] regAddr,
	input  wire logic [regDataWidth-1:0] regWrData,
	output logic      [regDataWidth-1:0] regRdData,
	// from the interval timer
	input  wire logic                    expire,
	// to the datapath
	output logic                         tickEn,
	output logic                         pwmEn,
	output logic                         timerEn,
	output logic                         autoReload,
	output logic      [cntWidth-1:0]     divider,
	output logic      [cntWidth-1:0]     pwmPeriod,
	output logic      [cntWidth-1:0]     pwmDuty,
	output logic      [cntWidth-1:0]     timerLoad,
	output logic                         irq
);

	logic [regDataWidth-1:0] ctrlReg;
	logic [regDataWidth-1:0] prescaleReg;
	logic [regDataWidth-1:0] pwmPeriodReg;
	logic [regDataWidth-1:0] pwmDutyReg;
	logic [regDataWidth-1:0] timerLoadReg;
	// sticky interrupt
	logic                    irqReg;
	// write of 1 to the status irq bit
	logic                    irqClr;
	logic [regDataWidth-1:0] statusWord;

	assign irqClr = regWr && (regAddr == addrStatus) && regWrData[statusIrqBit];

	//------------------------------------------------------------------
	// register writes
	//------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			ctrlReg      <= '0;
			prescaleReg  <= prescaleReset;
			pwmPeriodReg <= pwmPeriodReset;
			pwmDutyReg   <= pwmDutyReset;
			timerLoadReg <= timerLoadReset;
			irqReg       <= 1'b0;
		end
		else
		begin
			if (regWr)
			begin
				case (regAddr)
					addrCtrl:      ctrlReg      <= regWrData;
					addrPrescale:  prescaleReg  <= regWrData;
					addrPwmPeriod: pwmPeriodReg <= regWrData;
					addrPwmDuty:   pwmDutyReg   <= regWrData;
					addrTimerLoad: timerLoadReg <= regWrData;
					// status handled below
					default: ;
				endcase
			end
			// one-shot, timer stops on the expiry edge
			if (expire && !autoReload)
				ctrlReg[ctrlTimerEnBit] <= 1'b0;
			// a new expiry wins over a clear in the same cycle
			if (expire)
				irqReg <= 1'b1;
			else if (irqClr)
				irqReg <= 1'b0;
		end
	end

	// control fields out
	assign tickEn     = ctrlReg[ctrlTickEnBit];
	assign pwmEn      = ctrlReg[ctrlPwmEnBit];
	assign timerEn    = ctrlReg[ctrlTimerEnBit];
	assign autoReload = ctrlReg[ctrlAutoReloadBit];
	assign divider    = prescaleReg;
	assign pwmPeriod  = pwmPeriodReg;
	assign pwmDuty    = pwmDutyReg;
	assign timerLoad  = timerLoadReg;
	assign irq        = irqReg;

	//------------------------------------------------------------------
	// read-back mux
	//------------------------------------------------------------------
	always_comb
	begin
		statusWord               = '0;
		statusWord[statusIrqBit] = irqReg;
		case (regAddr)
			addrCtrl:      regRdData = ctrlReg;
			addrPrescale:  regRdData = prescaleReg;
			addrPwmPeriod: regRdData = pwmPeriodReg;
			addrPwmDuty:   regRdData = pwmDutyReg;
			addrTimerLoad: regRdData = timerLoadReg;
			addrStatus:    regRdData = statusWord;
			default:       regRdData = '0;
		endcase
	end

	// one-shot expiry stops the timer even against a control write
	assert property (@(posedge iSysClk) disable iff (!rstN)
		(expire && !autoReload) |=> !timerEn)
		else $error("tickTimerCtrl: timer still enabled after one-shot expire");

endmodule

`default_nettype wire

//--- tickTimerTop.sv
`default_nettype none
//----------------------------------------------------------------------
// tickTimerTop
// tick timer peripheral; register bank, shared prescaler, PWM output
// and interval timer with sticky interrupt
//----------------------------------------------------------------------
module tickTimerTop
	import tickTimerRegPkg::*, tickTimerCfgPkg::*;
(
	input  wire logic                    iSysClk,
	input  wire logic                    rstN,
	input  wire logic                    regWr,
	input  wire logic [regAddrWidth-1:0] regAddr,
	input  wire logic [regDataWidth-1:0] regWrData,
	output logic      [regDataWidth-1:0] regRdData,
	output logic                         pwmOut,
	output logic                         irq
);

	// control to datapath
	logic                tickEn;
	logic                pwmEn;
	logic                timerEn;
	logic [cntWidth-1:0] divider;
	logic [cntWidth-1:0] pwmPeriod;
	logic [cntWidth-1:0] pwmDuty;
	logic [cntWidth-1:0] timerLoad;
	// shared prescaler tick
	logic                tick;
	// timer back to control
	logic                expire;

	// one-shot handling stays inside the control block
	tickTimerCtrl uCtrl (
		.iSysClk    (iSysClk),
		.rstN       (rstN),
		.regWr      (regWr),
		.regAddr    (regAddr),
		.regWrData  (regWrData),
		.regRdData  (regRdData),
		.expire     (expire),
		.tickEn     (tickEn),
		.pwmEn      (pwmEn),
		.timerEn    (timerEn),
		.autoReload (),
		.divider    (divider),
		.pwmPeriod  (pwmPeriod),
		.pwmDuty    (pwmDuty),
		.timerLoad  (timerLoad),
		.irq        (irq)
	);

	ckeDivider uCkeDiv (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.tickEn  (tickEn),
		.divider (divider),
		.tick    (tick)
	);

	pwmGen uPwm (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.tick      (tick),
		.pwmEn     (pwmEn),
		.pwmPeriod (pwmPeriod),
		.pwmDuty   (pwmDuty),
		.pwmOut    (pwmOut)
	);

	intervalTimer uTimer (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.tick      (tick),
		.timerEn   (timerEn),
		.timerLoad (timerLoad),
		.expire    (expire)
	);

endmodule

`default_nettype wire

//--- tickTimerTb.sv
`default_nettype none
//----------------------------------------------------------------------
// tickTimerTb
// testbench of the tick timer; register read-back, interrupt interval,
// one-shot mode, PWM duty and idle checks against a reference model
//----------------------------------------------------------------------
module tickTimerTb
	import tickTimerRegPkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	// longest interval or PWM period, (7+1) x (15+1) cycles
	localparam int maxSpan = 128;
	// reset, regs, 4 intervals, one-shot, 3 PWM cases, idle; then doubled
	localparam int watchdogCycles =
		2 * (10 + 100 + 4 * 5 * maxSpan + 6 * maxSpan + 3 * 5 * maxSpan + 500);

	logic                    iSysClk;
	logic                    rstN;
	logic                    regWr;
	logic [regAddrWidth-1:0] regAddr;
	logic [regDataWidth-1:0] regWrData;
	logic [regDataWidth-1:0] regRdData;
	logic                    pwmOut;
	logic                    irq;
	// free-running stamp, sampled before the edge
	int                      cycleCnt = 0;
	logic [15:0]             lfsrState;
	string                   curTest;
	// pending checks, drained on the falling edge
	logic [31:0]             expQ[$];
	logic [31:0]             actQ[$];
	int                      testCnt = 0;
	int                      failCnt = 0;
	int                      checkCnt = 0;
	int                      errCnt = 0;
	int                      testErrs = 0;

	tickTimerTop i_dut (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.regWr     (regWr),
		.regAddr   (regAddr),
		.regWrData (regWrData),
		.regRdData (regRdData),
		.pwmOut    (pwmOut),
		.irq       (irq)
	);

	initial iSysClk = 1'b0;
	always #50 iSysClk = ~iSysClk;
	always @(posedge iSysClk) cycleCnt <= cycleCnt + 1;

	//------------------------------------------------------------------
	// random source and reference model
	//------------------------------------------------------------------
	// fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = {lfsrState[14:0],
				lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
			v = (v << 1) | lfsrState[0];
		end
		return v;
	endfunction

	// cycles between irq rises with auto reload
	function automatic int expInterval(input int pre, input int load);
		return (pre + 1) * (load + 1);
	endfunction

	// cycles in one PWM period
	function automatic int expPwmPeriod(input int pre, input int period);
		return (period + 1) * (pre + 1);
	endfunction

	// high cycles per period; duty saturates at period+1 ticks
	function automatic int expHighCount(input int pre, input int period, input int duty);
		return ((duty > period) ? period + 1 : duty) * (pre + 1);
	endfunction

	//------------------------------------------------------------------
	// register access and sampling
	//------------------------------------------------------------------
	task automatic writeReg(input logic [regAddrWidth-1:0] addr, input int data);
		@(posedge iSysClk);
		regWr     <= 1'b1;
		regAddr   <= addr;
		regWrData <= data;
		@(posedge iSysClk);
		regWr     <= 1'b0;
	endtask

	// read-back is combinational, valid one edge after the address
	task automatic readReg(input logic [regAddrWidth-1:0] addr, output logic [31:0] data);
		@(posedge iSysClk);
		regAddr <= addr;
		@(posedge iSysClk);
		data = regRdData;
	endtask

	// stamp of the first sample where pwmOut or irq goes 0 to 1
	task automatic waitRise(input bit usePwm, output int stamp);
		logic prev;
		logic cur;
		prev = usePwm ? pwmOut : irq;
		cur  = prev;
		while (!(cur && !prev))
		begin
			prev = cur;
			@(posedge iSysClk);
			cur = usePwm ? pwmOut : irq;
		end
		stamp = cycleCnt;
	endtask

	// high samples over a window, current sample included
	task automatic countHigh(input bit usePwm, input int cycles, output int highs);
		highs = 0;
		for (int i = 0; i < cycles; i++)
		begin
			if (i > 0)
				@(posedge iSysClk);
			if (usePwm ? pwmOut : irq)
				highs++;
		end
	endtask

	task automatic queueCheck(input logic [31:0] expVal, input logic [31:0] actVal);
		expQ.push_back(expVal);
		actQ.push_back(actVal);
	endtask

	// let the compare process drain, then report the test
	task automatic endTest();
		@(negedge iSysClk);
		#1;
		testCnt++;
		if (testErrs == 0)
			$display("test %s: ok", curTest);
		else
		begin
			$display("test %s: FAILED, %0d errors", curTest, testErrs);
			failCnt++;
		end
		testErrs = 0;
	endtask

	//------------------------------------------------------------------
	// compare process
	//------------------------------------------------------------------
	always @(negedge iSysClk)
	begin : compareChecks
		logic [31:0] e;
		logic [31:0] a;
		while (expQ.size() > 0)
		begin
			e = expQ.pop_front();
			a = actQ.pop_front();
			checkCnt++;
			if (e !== a)
			begin
				$display("** Error %s: expected %0d, actual %0d", curTest, e, a);
				errCnt++;
				testErrs++;
			end
		end
	end

	//------------------------------------------------------------------
	// stimulus
	//------------------------------------------------------------------
	initial
	begin : mainSeq
		int          pre;
		int          load;
		int          period;
		int          duty;
		int          ctrlVal;
		int          t1;
		int          t2;
		int          highs;
		int          wrVals[5];
		logic [31:0] val;
		lfsrState = 16'd22;
		rstN      <= 1'b0;
		regWr     <= 1'b0;
		regAddr   <= '0;
		regWrData <= '0;
		repeat (10) @(posedge iSysClk);
		rstN <= 1'b1;

		// reset state, then every data register
		curTest = "regs";
		@(posedge iSysClk);
		queueCheck(0, pwmOut);
		queueCheck(0, irq);
		readReg(addrStatus, val);
		queueCheck(0, val);
		for (int r = 0; r < 5; r++)
		begin
			wrVals[r] = randBits(16);
			// timer left off so no expiry touches the control word
			if (r == addrCtrl)
				wrVals[r] = wrVals[r] & ~(1 << ctrlTimerEnBit);
			writeReg(r, wrVals[r]);
		end
		for (int r = 0; r < 5; r++)
		begin
			readReg(r, val);
			queueCheck(wrVals[r], val);
		end
		writeReg(addrCtrl, 0);
		endTest();

		// auto reload, irq cleared at every rise
		curTest = "interval";
		for (int s = 0; s < 4; s++)
		begin
			pre  = randBits(3);
			load = randBits(4);
			// clear write needs a few cycles between rises
			if (expInterval(pre, load) < 8)
				load = load + 8;
			writeReg(addrCtrl, 0);
			writeReg(addrStatus, 1 << statusIrqBit);
			writeReg(addrPrescale, pre);
			writeReg(addrTimerLoad, load);
			writeReg(addrCtrl, (1 << ctrlTickEnBit) | (1 << ctrlTimerEnBit)
				| (1 << ctrlAutoReloadBit));
			waitRise(0, t1);
			writeReg(addrStatus, 1 << statusIrqBit);
			waitRise(0, t2);
			writeReg(addrStatus, 1 << statusIrqBit);
			queueCheck(expInterval(pre, load), t2 - t1);
		end
		writeReg(addrCtrl, 0);
		writeReg(addrStatus, 1 << statusIrqBit);
		endTest();

		// one-shot, hardware drops the timer enable
		curTest = "oneshot";
		pre     = randBits(3);
		load    = randBits(4);
		ctrlVal = (1 << ctrlTickEnBit) | (1 << ctrlTimerEnBit);
		writeReg(addrPrescale, pre);
		writeReg(addrTimerLoad, load);
		writeReg(addrCtrl, ctrlVal);
		waitRise(0, t1);
		readReg(addrCtrl, val);
		queueCheck(ctrlVal & ~(1 << ctrlTimerEnBit), val);
		writeReg(addrStatus, 1 << statusIrqBit);
		@(posedge iSysClk);
		countHigh(0, 2 * expInterval(pre, load), highs);
		queueCheck(0, highs);
		writeReg(addrCtrl, 0);
		endTest();

		// random duty, then zero duty, then duty above the period
		curTest = "pwm";
		for (int c = 0; c < 3; c++)
		begin
			pre    = randBits(3);
			period = randBits(4);
			duty   = randBits(4);
			if (c == 1)
				duty = 0;
			if (c == 2)
				duty = period + 1 + randBits(2);
			writeReg(addrCtrl, 0);
			writeReg(addrPrescale, pre);
			writeReg(addrPwmPeriod, period);
			writeReg(addrPwmDuty, duty);
			writeReg(addrCtrl, (1 << ctrlTickEnBit) | (1 << ctrlPwmEnBit));
			// zero duty never rises, just let a couple of ticks pass
			if (duty == 0)
				repeat (2 * (pre + 1)) @(posedge iSysClk);
			else
				waitRise(1, t1);
			countHigh(1, expPwmPeriod(pre, period), highs);
			queueCheck(expHighCount(pre, period, duty), highs);
			// next rise exactly one period on
			if (duty > 0 && duty <= period)
			begin
				waitRise(1, t2);
				queueCheck(expPwmPeriod(pre, period), t2 - t1);
			end
		end
		writeReg(addrCtrl, 0);
		endTest();

		// everything armed except the prescaler
		curTest = "idle";
		writeReg(addrPrescale, 0);
		writeReg(addrTimerLoad, 0);
		writeReg(addrPwmPeriod, 7);
		writeReg(addrPwmDuty, 5);
		writeReg(addrStatus, 1 << statusIrqBit);
		writeReg(addrCtrl, (1 << ctrlPwmEnBit) | (1 << ctrlTimerEnBit)
			| (1 << ctrlAutoReloadBit));
		countHigh(1, 200, highs);
		queueCheck(0, highs);
		countHigh(0, 200, highs);
		queueCheck(0, highs);
		endTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCnt, failCnt, checkCnt, errCnt);
		if (errCnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (watchdogCycles) @(posedge iSysClk);
		$display("watchdog: run did not complete within %0d cycles", watchdogCycles);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tickTimer.f
tickTimerCfgPkg.sv
tickTimerRegPkg.sv
ckeDivider.sv
pwmGen.sv
intervalTimer.sv
tickTimerCtrl.sv
tickTimerTop.sv
tickTimerTb.sv
